/* verilog/sysmon_macros.svh */
`ifndef SYSMON_MACROS_SVH
`define SYSMON_MACROS_SVH

// Clocks between scan starts
// On hardware this would be sysclk frequency / update rate
`define UPDATE_CYCLES 200

// Clocks to wait for DRDY before giving up on a read
`define DRP_TIMEOUT 16

// DRP status register addresses
`define ADDR_TEMP   7'h00
`define ADDR_VCCINT 7'h01
`define ADDR_VCCAUX 7'h02

// Over-temperature thresholds, set at or above, clear below
`define OT_SET_CODE 12'hB00
`define OT_CLR_CODE 12'hA80

// Supply window, inclusive, shared by VCCINT and VCCAUX
`define VCC_MIN_CODE 12'h500
`define VCC_MAX_CODE 12'h5C0

`endif

/* verilog/sysmon_pkg.sv */
// Shared types for the system monitor poller

package sysmon_pkg;

  // Status channel polled over the DRP, in scan order
  typedef enum logic [1:0] {
    CH_TEMP   = 2'd0,  // Internal temperature
    CH_VCCINT = 2'd1,  // Core supply
    CH_VCCAUX = 2'd2   // Auxiliary supply
  } chan_t;

  // Alarm flags
  // Fields listed MSB first so that over_temp lands in bit 0
  typedef struct packed {
    logic vccaux_alarm;  // VCCAUX outside its window
    logic vccint_alarm;  // VCCINT outside its window
    logic over_temp;     // Temperature alarm with hysteresis
  } alarm_t;

  // Host register map
  typedef enum logic [1:0] {
    REG_TEMP   = 2'd0,  // Latest temperature code
    REG_VCCINT = 2'd1,  // Latest VCCINT code
    REG_VCCAUX = 2'd2,  // Latest VCCAUX code
    REG_STATUS = 2'd3   // Alarms, DRP error and scan count
  } host_addr_t;

endpackage

/* verilog/drp_poller.sv */
`timescale 1ns/10ps
`include "sysmon_macros.svh"

// Periodic DRP reader
// Walks temperature, VCCINT and VCCAUX once per update period,
// one transaction at a time
module drp_poller (
  input  logic              clk,
  input  logic              rst,
  input  logic [15:0]       drp_do,       // Read data from the ADC block
  input  logic              drp_drdy,     // Read data valid
  output logic              drp_den,      // One-cycle enable per read
  output logic              drp_dwe,      // Reads only
  output logic [6:0]        drp_daddr,
  output logic              sample_valid, // Same cycle as DRDY
  output sysmon_pkg::chan_t sample_chan,
  output logic [11:0]       sample_code,  // Upper 12 bits of DO
  output logic              scan_done,    // One pulse per finished scan
  output logic              drp_error     // Sticky timeout flag
);

  localparam int TMR_W = $clog2(`UPDATE_CYCLES + 1);
  localparam int TMO_W = $clog2(`DRP_TIMEOUT + 1);
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`UPDATE_CYCLES - 1);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(`DRP_TIMEOUT - 1);

  typedef enum logic [1:0] {
    ST_IDLE, // Waiting for the update tick
    ST_WAIT, // DEN sent, waiting for DRDY
    ST_NEXT  // DEN high this cycle
  } state_t;

  state_t            state;
  sysmon_pkg::chan_t chan;      // Channel being read
  logic [TMR_W-1:0]  tmr;       // Update period counter
  logic [TMO_W-1:0]  tmo_cnt;   // Cycles spent in ST_WAIT
  logic              tick;      // Period wrap
  logic              drdy_hit;  // Read answered
  logic              tmo_hit;   // Read abandoned
  logic              xfer_end;
  logic              last_chan;

  // Scan order
  function automatic sysmon_pkg::chan_t next_chan(input sysmon_pkg::chan_t c);
    case (c)
      sysmon_pkg::CH_TEMP:   return sysmon_pkg::CH_VCCINT;
      sysmon_pkg::CH_VCCINT: return sysmon_pkg::CH_VCCAUX;
      default:               return sysmon_pkg::CH_TEMP;
    endcase
  endfunction

  // Channel index to DRP status address
  function automatic logic [6:0] chan_addr(input sysmon_pkg::chan_t c);
    case (c)
      sysmon_pkg::CH_VCCINT: return `ADDR_VCCINT;
      sysmon_pkg::CH_VCCAUX: return `ADDR_VCCAUX;
      default:               return `ADDR_TEMP;
    endcase
  endfunction

  assign tick      = (tmr == TMR_LAST);
  assign drdy_hit  = (state == ST_WAIT) && drp_drdy;
  assign tmo_hit   = (state == ST_WAIT) && !drp_drdy && (tmo_cnt == TMO_LAST);
  assign xfer_end  = drdy_hit || tmo_hit;
  assign last_chan = (chan == sysmon_pkg::CH_VCCAUX);

  // Free-running update timer, wraps every UPDATE_CYCLES clocks
  always_ff @(posedge clk) begin
    if (rst) begin
      tmr <= '0;
    end else if (tick) begin
      tmr <= '0;
    end else begin
      tmr <= tmr + 1'b1;
    end
  end

  // Read sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      chan      <= sysmon_pkg::CH_TEMP;
      tmo_cnt   <= '0;
      scan_done <= 1'b0;
      drp_error <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      if (tmo_hit) drp_error <= 1'b1; // Only reset clears it
      case (state)
        ST_IDLE: begin
          if (tick) begin           // Ticks outside idle are dropped
            chan  <= sysmon_pkg::CH_TEMP;
            state <= ST_NEXT;
          end
        end
        ST_NEXT: begin
          tmo_cnt <= '0;
          state   <= ST_WAIT;
        end
        ST_WAIT: begin
          if (xfer_end) begin
            if (last_chan) begin
              scan_done <= 1'b1;    // Cycle after the third transaction
              state     <= ST_IDLE;
            end else begin
              chan  <= next_chan(chan);
              state <= ST_NEXT;     // Next DEN in the following cycle
            end
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign drp_den   = (state == ST_NEXT);
  assign drp_dwe   = 1'b0;           // No writes in default sequencer mode
  assign drp_daddr = chan_addr(chan); // Held steady through the transaction

  // Sample path to the limit checker
  assign sample_valid = drdy_hit;
  assign sample_chan  = chan;
  assign sample_code  = drp_do[15:4]; // Result is left-justified in DO

endmodule

/* verilog/limit_checker.sv */
`timescale 1ns/10ps
`include "sysmon_macros.svh"

// Latest code per channel plus alarm evaluation
// Everything updates in the cycle after sample_valid
module limit_checker (
  input  logic               clk,
  input  logic               rst,
  input  logic               sample_valid,
  input  sysmon_pkg::chan_t  sample_chan,
  input  logic [11:0]        sample_code,
  output logic [11:0]        temp_code,
  output logic [11:0]        vccint_code,
  output logic [11:0]        vccaux_code,
  output sysmon_pkg::alarm_t alarms
);

  logic over_temp;     // Hysteresis state
  logic vccint_alarm;
  logic vccaux_alarm;
  logic ot_set;        // At or above the set threshold
  logic ot_clr;        // Below the clear threshold

  // Inclusive window check, used by both supplies
  function automatic logic out_of_window(input logic [11:0] code);
    return (code < `VCC_MIN_CODE) || (code > `VCC_MAX_CODE);
  endfunction

  assign ot_set = (sample_code >= `OT_SET_CODE);
  assign ot_clr = (sample_code <  `OT_CLR_CODE);

  // Code registers
  always_ff @(posedge clk) begin
    if (rst) begin
      temp_code   <= 12'h000;
      vccint_code <= 12'h000;
      vccaux_code <= 12'h000;
    end else if (sample_valid) begin
      case (sample_chan)
        sysmon_pkg::CH_TEMP:   temp_code   <= sample_code;
        sysmon_pkg::CH_VCCINT: vccint_code <= sample_code;
        sysmon_pkg::CH_VCCAUX: vccaux_code <= sample_code;
        default: ;             // Unused channel index
      endcase
    end
  end

  // Alarm state
  always_ff @(posedge clk) begin
    if (rst) begin
      over_temp    <= 1'b0;
      vccint_alarm <= 1'b0;
      vccaux_alarm <= 1'b0;
    end else if (sample_valid) begin
      case (sample_chan)
        sysmon_pkg::CH_TEMP: begin
          // Between the thresholds the alarm keeps its value
          if (ot_set) begin
            over_temp <= 1'b1;
          end else if (ot_clr) begin
            over_temp <= 1'b0;
          end
        end
        sysmon_pkg::CH_VCCINT: vccint_alarm <= out_of_window(sample_code);
        sysmon_pkg::CH_VCCAUX: vccaux_alarm <= out_of_window(sample_code);
        default: ;
      endcase
    end
  end

  assign alarms.over_temp    = over_temp;
  assign alarms.vccint_alarm = vccint_alarm;
  assign alarms.vccaux_alarm = vccaux_alarm;

endmodule

/* verilog/host_regs.sv */
`timescale 1ns/10ps

// Host read port
// Answers every read one clock after the strobe
module host_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   host_rd,     // One-cycle read strobe
  input  sysmon_pkg::host_addr_t host_addr,
  input  logic [11:0]            temp_code,
  input  logic [11:0]            vccint_code,
  input  logic [11:0]            vccaux_code,
  input  sysmon_pkg::alarm_t     alarms,
  input  logic                   drp_error,
  input  logic                   scan_done,   // Counted into the status word
  output logic [15:0]            host_rdata,
  output logic                   host_rvalid
);

  logic [7:0]  scan_cnt;    // Completed scans, wraps at 256
  logic [15:0] status_word;
  logic [15:0] rd_mux;

  // Status layout
  // [15:8] scan count, [3] DRP error, [2:0] alarms
  assign status_word = {
    scan_cnt,
    4'b0000,
    drp_error,
    alarms.vccaux_alarm,
    alarms.vccint_alarm,
    alarms.over_temp
  };

  // Address decode, codes zero-extended
  always_comb begin
    case (host_addr)
      sysmon_pkg::REG_TEMP:   rd_mux = {4'h0, temp_code};
      sysmon_pkg::REG_VCCINT: rd_mux = {4'h0, vccint_code};
      sysmon_pkg::REG_VCCAUX: rd_mux = {4'h0, vccaux_code};
      default:                rd_mux = status_word;
    endcase
  end

  // Valid strobe and scan counter
  always_ff @(posedge clk) begin
    if (rst) begin
      host_rvalid <= 1'b0;
      scan_cnt    <= 8'h00;
    end else begin
      host_rvalid <= host_rd;
      if (scan_done) scan_cnt <= scan_cnt + 8'h01;
    end
  end

  // Read data, only loaded on a strobe
  always_ff @(posedge clk) begin
    if (host_rd) host_rdata <= rd_mux;
  end

endmodule

/* verilog/sysmon_top.sv */
`timescale 1ns/10ps

// System monitor poller top level
// DRP goes to the ADC block outside, host port to the controller
module sysmon_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [15:0]            drp_do,
  input  logic                   drp_drdy,
  input  logic                   host_rd,
  input  sysmon_pkg::host_addr_t host_addr,
  output logic                   drp_den,
  output logic                   drp_dwe,
  output logic [6:0]             drp_daddr,
  output logic [15:0]            host_rdata,
  output logic                   host_rvalid,
  output logic                   otemp,     // Over-temperature alarm
  output logic                   scan_done,
  output logic                   drp_error
);

  logic               sample_valid;
  sysmon_pkg::chan_t  sample_chan;
  logic [11:0]        sample_code;
  logic [11:0]        temp_code;
  logic [11:0]        vccint_code;
  logic [11:0]        vccaux_code;
  sysmon_pkg::alarm_t alarms;

  // DRP read sequencer
  drp_poller i_drp_poller (
    .clk          (clk),
    .rst          (rst),
    .drp_do       (drp_do),
    .drp_drdy     (drp_drdy),
    .drp_den      (drp_den),
    .drp_dwe      (drp_dwe),
    .drp_daddr    (drp_daddr),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_code  (sample_code),
    .scan_done    (scan_done),
    .drp_error    (drp_error)
  );

  // Codes and alarms
  limit_checker i_limit_checker (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_code  (sample_code),
    .temp_code    (temp_code),
    .vccint_code  (vccint_code),
    .vccaux_code  (vccaux_code),
    .alarms       (alarms)
  );

  // Host-visible registers
  host_regs i_host_regs (
    .clk         (clk),
    .rst         (rst),
    .host_rd     (host_rd),
    .host_addr   (host_addr),
    .temp_code   (temp_code),
    .vccint_code (vccint_code),
    .vccaux_code (vccaux_code),
    .alarms      (alarms),
    .drp_error   (drp_error),
    .scan_done   (scan_done),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid)
  );

  assign otemp = alarms.over_temp;

endmodule

/* tests/sysmon_checker.sv */
`timescale 1ns/10ps

// Result checker for the system monitor testbench
// Compares host reads with expected values and watches the DRP read order
module sysmon_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        drp_den,
  input  logic        drp_dwe,
  input  logic [6:0]  drp_daddr,
  input  logic [15:0] host_rdata,
  input  logic        otemp,
  input  logic        drp_error,
  input  logic        cmp_en,     // Compare on this rising edge
  input  logic [1:0]  cmp_addr,   // Register that was read
  input  logic [15:0] exp_rdata,
  input  logic        exp_otemp,
  input  logic        exp_drp_error,
  input  logic [95:0] test_name,
  input  logic        test_end,   // Closes the current test
  input  logic        report,     // Closing counts
  output int          err_count
);

  int         cmp_errs   = 0;  // Host read mismatches
  int         addr_errs  = 0;  // DRP order and write-enable mismatches
  int         errs_start = 0;  // Error total when the current test began
  int         tests      = 0;
  int         failed     = 0;
  logic [1:0] next_idx;        // Channel of the next DEN

  assign err_count = cmp_errs + addr_errs;

  // DEN is registered in the DUT, so the falling edge sees it settled
  always @(negedge clk) begin
    if (rst) begin
      next_idx = 2'd0;
    end else if (drp_den) begin
      if (drp_daddr !== {5'b00000, next_idx}) begin
        $display("CHECK FAILED %0s: drp_daddr expected 0x%02h actual 0x%02h",
                 test_name, {5'b00000, next_idx}, drp_daddr);
        addr_errs++;
      end
      if (drp_dwe !== 1'b0) begin
        $display("CHECK FAILED %0s: drp_dwe expected 0 actual %0b", test_name, drp_dwe);
        addr_errs++;
      end
      next_idx = (next_idx == 2'd2) ? 2'd0 : next_idx + 2'd1; // Temp, VCCINT, VCCAUX
    end
  end

  always @(posedge clk) begin
    if (cmp_en) begin
      if (host_rdata !== exp_rdata) begin
        $display("CHECK FAILED %0s: register %0d expected 0x%04h actual 0x%04h",
                 test_name, cmp_addr, exp_rdata, host_rdata);
        cmp_errs++;
      end
      if (otemp !== exp_otemp) begin
        $display("CHECK FAILED %0s: otemp expected %0b actual %0b",
                 test_name, exp_otemp, otemp);
        cmp_errs++;
      end
      if (drp_error !== exp_drp_error) begin
        $display("CHECK FAILED %0s: drp_error expected %0b actual %0b",
                 test_name, exp_drp_error, drp_error);
        cmp_errs++;
      end
    end
    if (test_end) begin
      tests++;
      if (cmp_errs + addr_errs != errs_start) begin
        failed++;
        $display("FAIL %0s", test_name);
      end else begin
        $display("PASS %0s", test_name);
      end
      errs_start = cmp_errs + addr_errs;
    end
    if (report) begin
      $display("Summary: %0d tests run, %0d ok, %0d failing, %0d check errors",
               tests, tests - failed, failed, cmp_errs + addr_errs);
    end
  end

endmodule

/* tests/tb_sysmon.sv */
`timescale 1ns/10ps
`include "sysmon_macros.svh"

// System monitor poller testbench
// Acts as the ADC block on the DRP and reads the results back over the host port
module tb_sysmon;

  localparam int n_fixed  = 10;             // Hand-checked rows, reset row first
  localparam int n_rows   = n_fixed + 6;    // Then random scans
  localparam int scan_tmo = 4 * `UPDATE_CYCLES;

  logic                   clk;
  logic                   rst;
  logic [15:0]            drp_do;
  logic                   drp_drdy;
  logic                   host_rd;
  sysmon_pkg::host_addr_t host_addr;
  logic                   drp_den;
  logic                   drp_dwe;
  logic [6:0]             drp_daddr;
  logic [15:0]            host_rdata;
  logic                   host_rvalid;
  logic                   otemp;
  logic                   scan_done;
  logic                   drp_error;

  logic        cmp_en;     // Checker compares on the next rising edge
  logic [1:0]  cmp_addr;
  logic [15:0] exp_rdata;
  logic        exp_otemp;
  logic        exp_drp_error;
  logic [95:0] test_name;
  logic        test_end;
  logic        report;
  logic        timed_out;  // A wait ran out of cycles
  int          err_count;

  // Stimulus table
  logic [95:0] row_name   [n_rows];
  bit          row_scan   [n_rows];     // 0 for the reset row
  logic [11:0] row_code   [n_rows][3];  // Temp, VCCINT, VCCAUX
  int          row_delay  [n_rows];     // DRDY 1 to 16 clocks after DEN
  logic [2:0]  row_silent [n_rows];     // Channels left unanswered
  logic [11:0] row_exp    [n_rows][3];
  logic [3:0]  row_stat   [n_rows];     // {error, vccaux, vccint, over_temp}

  logic [11:0] cur_code [3];            // Responder data for the running scan
  int          cur_delay;
  logic [2:0]  cur_silent;
  logic [3:0]  cur_low;                 // Filler in DO bits 3:0

  logic [11:0] m_code [3];              // Reference model
  logic [2:0]  m_alarm;
  logic        m_err;
  logic [31:0] rng;
  logic [7:0]  scans;                   // Expected scan count

  sysmon_top i_sysmon_top (
    .clk         (clk),
    .rst         (rst),
    .drp_do      (drp_do),
    .drp_drdy    (drp_drdy),
    .host_rd     (host_rd),
    .host_addr   (host_addr),
    .drp_den     (drp_den),
    .drp_dwe     (drp_dwe),
    .drp_daddr   (drp_daddr),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .otemp       (otemp),
    .scan_done   (scan_done),
    .drp_error   (drp_error)
  );

  sysmon_checker i_sysmon_checker (
    .clk           (clk),
    .rst           (rst),
    .drp_den       (drp_den),
    .drp_dwe       (drp_dwe),
    .drp_daddr     (drp_daddr),
    .host_rdata    (host_rdata),
    .otemp         (otemp),
    .drp_error     (drp_error),
    .cmp_en        (cmp_en),
    .cmp_addr      (cmp_addr),
    .exp_rdata     (exp_rdata),
    .exp_otemp     (exp_otemp),
    .exp_drp_error (exp_drp_error),
    .test_name     (test_name),
    .test_end      (test_end),
    .report        (report),
    .err_count     (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;              // 8 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic set_row(input int i, input logic [95:0] name, input bit scan,
                         input logic [11:0] t, input logic [11:0] vi, input logic [11:0] vx,
                         input int dly, input logic [2:0] sil, input logic [11:0] et,
                         input logic [11:0] evi, input logic [11:0] evx, input logic [3:0] st);
    row_name[i]   = name;
    row_scan[i]   = scan;
    row_code[i]   = '{t, vi, vx};
    row_delay[i]  = dly;
    row_silent[i] = sil;
    row_exp[i]    = '{et, evi, evx};
    row_stat[i]   = st;
  endtask

  task automatic random_row(input int i);
    rng = xorshift32(rng);
    row_name[i]    = "random";
    row_scan[i]    = 1'b1;
    row_code[i][0] = 12'hA40 + 12'(rng[7:0]);           // Straddles both temp limits
    row_code[i][1] = 12'h480 + 12'({rng[15:8], 1'b0});  // Below, inside and above window
    row_code[i][2] = 12'h480 + 12'({rng[23:16], 1'b0});
    row_delay[i]   = 1 + int'(rng[27:24]);
    row_silent[i]  = (rng[31:29] == 3'b000) ? 3'b100 : 3'b000; // Now and then a lost VCCAUX
    cur_low        = rng[3:0];
  endtask

  // Apply one scan's samples to the reference model
  task automatic model_scan(input int i);
    for (logic [1:0] ch = 2'd0; ch < 2'd3; ch++) begin
      if (row_silent[i][ch]) begin
        m_err = 1'b1;                   // Timed out, old code stays
      end else begin
        m_code[ch] = row_code[i][ch];
        if (ch == 2'd0) begin
          if (row_code[i][0] >= `OT_SET_CODE) m_alarm[0] = 1'b1;
          else if (row_code[i][0] < `OT_CLR_CODE) m_alarm[0] = 1'b0;
        end else begin
          m_alarm[ch] = (row_code[i][ch] < `VCC_MIN_CODE) || (row_code[i][ch] > `VCC_MAX_CODE);
        end
      end
    end
  endtask

  task automatic flag_timeout(input string what);
    $display("Timed out waiting for %0s during %0s", what, test_name);
    timed_out = 1'b1;
  endtask

  task automatic wait_scan();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < scan_tmo; n++) begin
      @(negedge clk);
      if (scan_done) begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen) flag_timeout("scan_done");
  endtask

  // One host read, then the expected value goes to the checker
  task automatic host_read(input sysmon_pkg::host_addr_t a, input logic [15:0] exp_val,
                           input logic exp_ot);
    logic seen;
    seen      = 1'b0;
    host_addr = a;
    host_rd   = 1'b1;
    for (int n = 0; n < 4; n++) begin
      @(negedge clk);
      host_rd = 1'b0;
      if (host_rvalid) begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen) begin
      flag_timeout("host_rvalid");
    end else begin
      cmp_addr  = a;
      exp_rdata = exp_val;
      exp_otemp = exp_ot;
      cmp_en    = 1'b1;
      @(negedge clk);
      cmp_en = 1'b0;
    end
  endtask

  task automatic check_row(input int i);
    exp_drp_error = row_stat[i][3];
    host_read(sysmon_pkg::REG_TEMP, {4'h0, row_exp[i][0]}, row_stat[i][0]);
    if (!timed_out) host_read(sysmon_pkg::REG_VCCINT, {4'h0, row_exp[i][1]}, row_stat[i][0]);
    if (!timed_out) host_read(sysmon_pkg::REG_VCCAUX, {4'h0, row_exp[i][2]}, row_stat[i][0]);
    if (!timed_out) host_read(sysmon_pkg::REG_STATUS, {scans, 4'h0, row_stat[i]}, row_stat[i][0]);
    if (!timed_out) begin
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
    end
  endtask

  // DRP responder, answers each DEN from the current row
  initial begin
    logic [1:0] ch;
    drp_do   = 16'h0000;
    drp_drdy = 1'b0;
    forever begin
      @(negedge clk);
      drp_drdy = 1'b0;
      drp_do   = 16'h0000;
      if (drp_den) begin
        ch = drp_daddr[1:0];
        if (ch != 2'd3 && !cur_silent[ch]) begin
          repeat (cur_delay) @(negedge clk);
          drp_do   = {cur_code[ch], cur_low}; // Left-justified like the ADC
          drp_drdy = 1'b1;
        end
      end
    end
  end

  initial begin
    rst       = 1'b1;
    host_rd   = 1'b0;
    host_addr = sysmon_pkg::REG_TEMP;
    cmp_en    = 1'b0;
    cmp_addr  = 2'd0;
    exp_rdata = 16'h0000;
    exp_otemp = 1'b0;
    exp_drp_error = 1'b0;
    test_name = "reset";
    test_end  = 1'b0;
    report    = 1'b0;
    timed_out = 1'b0;
    cur_code  = '{default: 12'h000};
    cur_delay = 1;
    cur_silent = 3'b000;
    cur_low   = 4'hC;
    m_code    = '{default: 12'h000};
    m_alarm   = 3'b000;
    m_err     = 1'b0;
    rng       = 32'd3171;
    scans     = 8'h00;
    set_row(0, "reset", 0, 12'h000, 12'h000, 12'h000, 1, 3'b000, 12'h000, 12'h000, 12'h000, 4'h0);
    set_row(1, "normal", 1, 12'h8F3, 12'h540, 12'h580, 3, 3'b000, 12'h8F3, 12'h540, 12'h580, 4'h0);
    set_row(2, "ot_set", 1, 12'hB10, 12'h540, 12'h580, 1, 3'b000, 12'hB10, 12'h540, 12'h580, 4'h1);
    set_row(3, "ot_hold", 1, 12'hAA0, 12'h548, 12'h588, 5, 3'b000, 12'hAA0, 12'h548, 12'h588, 4'h1);
    set_row(4, "ot_clear", 1, 12'hA70, 12'h550, 12'h590, 2, 3'b000, 12'hA70, 12'h550, 12'h590, 4'h0);
    set_row(5, "vcc_low", 1, 12'h900, 12'h4FF, 12'h480, 8, 3'b000, 12'h900, 12'h4FF, 12'h480, 4'h6);
    set_row(6, "vcc_inside", 1, 12'h905, 12'h500, 12'h5C0, 1, 3'b000, 12'h905, 12'h500, 12'h5C0, 4'h0);
    set_row(7, "vcc_high", 1, 12'h910, 12'h5C1, 12'h700, 12, 3'b000, 12'h910, 12'h5C1, 12'h700, 4'h6);
    set_row(8, "no_vccint", 1, 12'h950, 12'h530, 12'h560, 4, 3'b010, 12'h950, 12'h5C1, 12'h560, 4'hA);
    set_row(9, "err_sticky", 1, 12'h960, 12'h520, 12'h510, 16, 3'b000, 12'h960, 12'h520, 12'h510, 4'h8);
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      if (i >= n_fixed) random_row(i);
      test_name = row_name[i];
      if (row_scan[i]) begin
        cur_code   = row_code[i];
        cur_delay  = row_delay[i];
        cur_silent = row_silent[i];
        wait_scan();
        if (timed_out) break;
        scans++;
        model_scan(i);
        if (i >= n_fixed) begin
          row_exp[i]  = m_code;
          row_stat[i] = {m_err, m_alarm};
        end
      end
      check_row(i);
      if (timed_out) break;
    end
    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    if (err_count == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/sysmon_pkg.sv
verilog/drp_poller.sv
verilog/limit_checker.sv
verilog/host_regs.sv
verilog/sysmon_top.sv
tests/sysmon_checker.sv
tests/tb_sysmon.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module tb_sysmon -o sim_sysmon || exit 1
out=$(./obj_dir/sim_sysmon)
echo "$out"
echo "$out" | grep -qx "test passed" && echo "simulation ok" && exit 0 || exit 1
